// ==== source/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

	// --------------------
	// data width
	// --------------------
	localparam int xlen = 32;

	// iteration counter of the multiply and divide units
	localparam int iter_count_bits = 6;

	// --------------------
	// operations
	// --------------------
	typedef enum logic [4:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and,
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_beq,
		op_bne,
		op_blt,
		op_bge,
		op_bltu,
		op_bgeu,
		op_mul,
		op_mulh,
		op_mulhsu,
		op_mulhu,
		op_div,
		op_divu,
		op_rem,
		op_remu
	} alu_op_e;

	// state of the iterative units
	typedef enum logic [1:0] {
		iter_idle,
		iter_busy,
		iter_done
	} iter_state_e;

endpackage

`default_nettype wire

// ==== source/exu_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_adder (
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	input  logic                     is_sub,
	output logic [exu_pkg::xlen-1:0] sum,
	output logic                     zero_flag,
	output logic                     signed_less,
	output logic                     unsigned_less
);

	logic [exu_pkg::xlen-1:0] b_eff;
	logic                     carry_out;

	// subtract as a + ~b + 1
	assign b_eff = is_sub ? ~b : b;
	assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{exu_pkg::xlen{1'b0}}, is_sub};

	// flags are meaningful when is_sub is set
	assign zero_flag = (sum == '0);

	// no carry out of a - b means a borrow, so a < b unsigned
	assign unsigned_less = ~carry_out;

	// differing signs decide directly, otherwise the difference sign does
	assign signed_less = (a[exu_pkg::xlen-1] ^ b[exu_pkg::xlen-1]) ?
		a[exu_pkg::xlen-1] : sum[exu_pkg::xlen-1];

endmodule

`default_nettype wire

// ==== source/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
	input  exu_pkg::alu_op_e         op,
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	input  logic [exu_pkg::xlen-1:0] sum,
	input  logic [exu_pkg::xlen-1:0] pc_sum,
	input  logic                     signed_less,
	input  logic                     unsigned_less,
	output logic [exu_pkg::xlen-1:0] result
);

	logic [4:0] shamt;

	// only the low five bits count as shift amount
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			exu_pkg::op_add,
			exu_pkg::op_sub: begin
				result = sum;
			end
			exu_pkg::op_slt: begin
				result = {{(exu_pkg::xlen-1){1'b0}}, signed_less};
			end
			exu_pkg::op_sltu: begin
				result = {{(exu_pkg::xlen-1){1'b0}}, unsigned_less};
			end
			exu_pkg::op_xor: begin
				result = a ^ b;
			end
			exu_pkg::op_or: begin
				result = a | b;
			end
			exu_pkg::op_and: begin
				result = a & b;
			end
			exu_pkg::op_sll: begin
				result = a << shamt;
			end
			exu_pkg::op_srl: begin
				result = a >> shamt;
			end
			exu_pkg::op_sra: begin
				result = $unsigned($signed(a) >>> shamt);
			end
			exu_pkg::op_lui: begin
				result = b;
			end
			// link address or pc relative value
			exu_pkg::op_auipc,
			exu_pkg::op_jal,
			exu_pkg::op_jalr: begin
				result = pc_sum;
			end
			// branches write nothing, mul/div come from their own units
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/exu_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_branch (
	input  exu_pkg::alu_op_e op,
	input  logic             zero_flag,
	input  logic             signed_less,
	input  logic             unsigned_less,
	output logic             taken
);

	// flags come from src1 - src2 on the operand adder
	always_comb begin
		case (op)
			exu_pkg::op_beq:  taken = zero_flag;
			exu_pkg::op_bne:  taken = ~zero_flag;
			exu_pkg::op_blt:  taken = signed_less;
			exu_pkg::op_bge:  taken = ~signed_less;
			exu_pkg::op_bltu: taken = unsigned_less;
			exu_pkg::op_bgeu: taken = ~unsigned_less;
			// jumps always redirect
			exu_pkg::op_jal,
			exu_pkg::op_jalr: taken = 1'b1;
			default: begin
				taken = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/exu_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_mul (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  logic                     a_signed,
	input  logic                     b_signed,
	input  logic                     high_half,
	input  logic [exu_pkg::xlen-1:0] a,
	input  logic [exu_pkg::xlen-1:0] b,
	output logic                     done,
	output logic [exu_pkg::xlen-1:0] product
);

	exu_pkg::iter_state_e                state_q;
	logic [exu_pkg::iter_count_bits-1:0] count_q;
	logic [2*exu_pkg::xlen-1:0]          acc_q;
	logic [exu_pkg::xlen-1:0]            mcand_q;
	logic                                negate_q;
	logic                                high_q;
	logic                                a_neg;
	logic                                b_neg;
	logic                                last_step;
	logic [exu_pkg::xlen-1:0]            addend;
	logic [exu_pkg::xlen:0]              upper_sum;
	logic [2*exu_pkg::xlen-1:0]          acc_next;
	logic [2*exu_pkg::xlen-1:0]          acc_final;

	assign a_neg = a_signed & a[exu_pkg::xlen-1];
	assign b_neg = b_signed & b[exu_pkg::xlen-1];

	assign last_step = (count_q == exu_pkg::iter_count_bits'(exu_pkg::xlen - 1));

	// --------------------
	// shift-add datapath
	// --------------------
	// low half of acc holds the remaining multiplier bits
	assign addend    = acc_q[0] ? mcand_q : '0;
	assign upper_sum = {1'b0, acc_q[2*exu_pkg::xlen-1:exu_pkg::xlen]} + {1'b0, addend};
	assign acc_next  = {upper_sum, acc_q[exu_pkg::xlen-1:1]};

	// sign step folded into the last add
	assign acc_final = negate_q ? (~acc_next + 1'b1) : acc_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= exu_pkg::iter_idle;
			count_q <= '0;
		end else begin
			case (state_q)
				exu_pkg::iter_idle: begin
					if (start) begin
						state_q <= exu_pkg::iter_busy;
						count_q <= '0;
					end
				end
				exu_pkg::iter_busy: begin
					count_q <= count_q + 1'b1;
					if (last_step) begin
						state_q <= exu_pkg::iter_done;
					end
				end
				default: begin
					state_q <= exu_pkg::iter_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == exu_pkg::iter_idle && start) begin
			mcand_q  <= a_neg ? (~a + 1'b1) : a;
			acc_q    <= {{exu_pkg::xlen{1'b0}}, (b_neg ? (~b + 1'b1) : b)};
			negate_q <= a_neg ^ b_neg;
			high_q   <= high_half;
		end else if (state_q == exu_pkg::iter_busy) begin
			acc_q <= acc_next;
			if (last_step) begin
				product <= high_q ? acc_final[2*exu_pkg::xlen-1:exu_pkg::xlen] :
					acc_final[exu_pkg::xlen-1:0];
			end
		end
	end

	assign done = (state_q == exu_pkg::iter_done);

	// the execute stage must wait for the previous product
	start_when_idle: assert property (@(posedge clock) disable iff (reset)
		start |-> state_q == exu_pkg::iter_idle);

endmodule

`default_nettype wire

// ==== source/exu_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_div (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  logic                     is_signed,
	input  logic                     want_rem,
	input  logic [exu_pkg::xlen-1:0] dividend,
	input  logic [exu_pkg::xlen-1:0] divisor,
	output logic                     done,
	output logic [exu_pkg::xlen-1:0] quotient_or_rem
);

	exu_pkg::iter_state_e                state_q;
	logic [exu_pkg::iter_count_bits-1:0] count_q;
	logic [exu_pkg::xlen-1:0]            rem_q;
	logic [exu_pkg::xlen-1:0]            quo_q;
	logic [exu_pkg::xlen-1:0]            dvsr_q;
	logic                                neg_quo_q;
	logic                                neg_rem_q;
	logic                                want_rem_q;
	logic                                dividend_neg;
	logic                                divisor_neg;
	logic                                sign_step;
	logic [exu_pkg::xlen:0]              shifted;
	logic [exu_pkg::xlen:0]              trial;

	assign dividend_neg = is_signed & dividend[exu_pkg::xlen-1];
	assign divisor_neg  = is_signed & divisor[exu_pkg::xlen-1];

	// one step per quotient bit and then the sign step
	assign sign_step = (count_q == exu_pkg::iter_count_bits'(exu_pkg::xlen));

	// --------------------
	// restoring step
	// --------------------
	assign shifted = {rem_q, quo_q[exu_pkg::xlen-1]};
	assign trial   = shifted - {1'b0, dvsr_q};

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= exu_pkg::iter_idle;
			count_q <= '0;
		end else begin
			case (state_q)
				exu_pkg::iter_idle: begin
					if (start) begin
						state_q <= exu_pkg::iter_busy;
						count_q <= '0;
					end
				end
				exu_pkg::iter_busy: begin
					count_q <= count_q + 1'b1;
					if (sign_step) begin
						state_q <= exu_pkg::iter_done;
					end
				end
				default: begin
					state_q <= exu_pkg::iter_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == exu_pkg::iter_idle && start) begin
			rem_q  <= '0;
			quo_q  <= dividend_neg ? (~dividend + 1'b1) : dividend;
			dvsr_q <= divisor_neg ? (~divisor + 1'b1) : divisor;
			// a zero divisor leaves an unsigned all-ones quotient
			neg_quo_q  <= (dividend_neg ^ divisor_neg) & (divisor != '0);
			neg_rem_q  <= dividend_neg;
			want_rem_q <= want_rem;
		end else if (state_q == exu_pkg::iter_busy) begin
			if (sign_step) begin
				// min / -1 comes out as min with remainder 0 on its own
				if (want_rem_q) begin
					quotient_or_rem <= neg_rem_q ? (~rem_q + 1'b1) : rem_q;
				end else begin
					quotient_or_rem <= neg_quo_q ? (~quo_q + 1'b1) : quo_q;
				end
			end else begin
				quo_q <= {quo_q[exu_pkg::xlen-2:0], ~trial[exu_pkg::xlen]};
				if (trial[exu_pkg::xlen]) begin
					rem_q <= shifted[exu_pkg::xlen-1:0];
				end else begin
					rem_q <= trial[exu_pkg::xlen-1:0];
				end
			end
		end
	end

	assign done = (state_q == exu_pkg::iter_done);

	// done follows start after every step and the sign step, for a single cycle
	done_single_cycle: assert property (@(posedge clock) disable iff (reset)
		start |-> ##(exu_pkg::xlen + 2) done ##1 !done);

endmodule

`default_nettype wire

// ==== source/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  exu_pkg::alu_op_e         op,
	input  logic [exu_pkg::xlen-1:0] pc,
	input  logic [exu_pkg::xlen-1:0] src1,
	input  logic [exu_pkg::xlen-1:0] src2,
	input  logic [exu_pkg::xlen-1:0] imm,
	input  logic                     b_sel,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [exu_pkg::xlen-1:0] result,
	output logic                     branch_taken,
	output logic [exu_pkg::xlen-1:0] target
);

	exu_pkg::alu_op_e         op_q;
	logic [exu_pkg::xlen-1:0] pc_q;
	logic [exu_pkg::xlen-1:0] src1_q;
	logic [exu_pkg::xlen-1:0] b_q;
	logic [exu_pkg::xlen-1:0] imm_q;
	logic                     holding_q;
	logic                     dispatch_q;
	logic                     fire_in;
	logic                     fire_out;

	// decoded controls
	logic is_mul;
	logic is_div;
	logic sub_sel;
	logic pc_imm_sel;
	logic mul_a_signed;
	logic mul_b_signed;
	logic mul_high;
	logic div_signed;
	logic div_rem;

	logic [exu_pkg::xlen-1:0] op_a;
	logic [exu_pkg::xlen-1:0] op_b;
	logic [exu_pkg::xlen-1:0] op_sum;
	logic [exu_pkg::xlen-1:0] pc_sum;
	logic                     zero_flag;
	logic                     signed_less;
	logic                     unsigned_less;
	logic [exu_pkg::xlen-1:0] alu_result;
	logic                     taken;
	logic [exu_pkg::xlen-1:0] target_c;
	logic                     mul_done;
	logic [exu_pkg::xlen-1:0] mul_product;
	logic                     div_done;
	logic [exu_pkg::xlen-1:0] div_result;

	// --------------------
	// handshakes
	// --------------------
	assign in_ready = ~holding_q;
	assign fire_in  = in_valid & in_ready;
	assign fire_out = out_valid & out_ready;

	always_ff @(posedge clock) begin
		if (fire_in) begin
			op_q   <= op;
			pc_q   <= pc;
			src1_q <= src1;
			b_q    <= b_sel ? src2 : imm;
			imm_q  <= imm;
		end
	end

	always_comb begin
		is_mul       = 1'b0;
		is_div       = 1'b0;
		sub_sel      = 1'b0;
		pc_imm_sel   = 1'b0;
		mul_a_signed = 1'b0;
		mul_b_signed = 1'b0;
		mul_high     = 1'b0;
		div_signed   = 1'b0;
		div_rem      = 1'b0;
		case (op_q)
			exu_pkg::op_sub,
			exu_pkg::op_slt,
			exu_pkg::op_sltu: begin
				sub_sel = 1'b1;
			end
			exu_pkg::op_beq,
			exu_pkg::op_bne,
			exu_pkg::op_blt,
			exu_pkg::op_bge,
			exu_pkg::op_bltu,
			exu_pkg::op_bgeu: begin
				sub_sel    = 1'b1;
				pc_imm_sel = 1'b1;
			end
			exu_pkg::op_auipc: begin
				pc_imm_sel = 1'b1;
			end
			// low half is the same for signed and unsigned
			exu_pkg::op_mul: begin
				is_mul = 1'b1;
			end
			exu_pkg::op_mulh: begin
				is_mul       = 1'b1;
				mul_a_signed = 1'b1;
				mul_b_signed = 1'b1;
				mul_high     = 1'b1;
			end
			exu_pkg::op_mulhsu: begin
				is_mul       = 1'b1;
				mul_a_signed = 1'b1;
				mul_high     = 1'b1;
			end
			exu_pkg::op_mulhu: begin
				is_mul   = 1'b1;
				mul_high = 1'b1;
			end
			exu_pkg::op_div: begin
				is_div     = 1'b1;
				div_signed = 1'b1;
			end
			exu_pkg::op_divu: begin
				is_div = 1'b1;
			end
			exu_pkg::op_rem: begin
				is_div     = 1'b1;
				div_signed = 1'b1;
				div_rem    = 1'b1;
			end
			exu_pkg::op_remu: begin
				is_div  = 1'b1;
				div_rem = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// --------------------
	// datapath
	// --------------------
	// jump targets come from the operand adder
	// jal adds imm to pc and jalr adds imm to src1, the pc adder keeps pc + 4
	assign op_a = (op_q == exu_pkg::op_jal) ? pc_q : src1_q;
	assign op_b = (op_q == exu_pkg::op_jal || op_q == exu_pkg::op_jalr) ? imm_q : b_q;

	exu_adder u_op_adder (
		.a             (op_a),
		.b             (op_b),
		.is_sub        (sub_sel),
		.sum           (op_sum),
		.zero_flag     (zero_flag),
		.signed_less   (signed_less),
		.unsigned_less (unsigned_less)
	);

	exu_adder u_pc_adder (
		.a             (pc_q),
		.b             (pc_imm_sel ? imm_q : exu_pkg::xlen'(4)),
		.is_sub        (1'b0),
		.sum           (pc_sum),
		.zero_flag     (),
		.signed_less   (),
		.unsigned_less ()
	);

	exu_alu u_alu (
		.op            (op_q),
		.a             (src1_q),
		.b             (b_q),
		.sum           (op_sum),
		.pc_sum        (pc_sum),
		.signed_less   (signed_less),
		.unsigned_less (unsigned_less),
		.result        (alu_result)
	);

	exu_branch u_branch (
		.op            (op_q),
		.zero_flag     (zero_flag),
		.signed_less   (signed_less),
		.unsigned_less (unsigned_less),
		.taken         (taken)
	);

	always_comb begin
		case (op_q)
			exu_pkg::op_beq,
			exu_pkg::op_bne,
			exu_pkg::op_blt,
			exu_pkg::op_bge,
			exu_pkg::op_bltu,
			exu_pkg::op_bgeu: target_c = pc_sum;
			exu_pkg::op_jal:  target_c = op_sum;
			exu_pkg::op_jalr: target_c = {op_sum[exu_pkg::xlen-1:1], 1'b0};
			default: begin
				target_c = '0;
			end
		endcase
	end

	// iterative units get one start pulse in the cycle after accept
	exu_mul u_mul (
		.clock     (clock),
		.reset     (reset),
		.start     (dispatch_q & is_mul),
		.a_signed  (mul_a_signed),
		.b_signed  (mul_b_signed),
		.high_half (mul_high),
		.a         (src1_q),
		.b         (b_q),
		.done      (mul_done),
		.product   (mul_product)
	);

	exu_div u_div (
		.clock           (clock),
		.reset           (reset),
		.start           (dispatch_q & is_div),
		.is_signed       (div_signed),
		.want_rem        (div_rem),
		.dividend        (src1_q),
		.divisor         (b_q),
		.done            (div_done),
		.quotient_or_rem (div_result)
	);

	// --------------------
	// control and output register
	// --------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			holding_q  <= 1'b0;
			dispatch_q <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			dispatch_q <= fire_in;
			if (fire_in) begin
				holding_q <= 1'b1;
			end
			if ((dispatch_q & ~is_mul & ~is_div) | mul_done | div_done) begin
				out_valid <= 1'b1;
			end else if (fire_out) begin
				out_valid <= 1'b0;
				holding_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch_q & ~is_mul & ~is_div) begin
			result       <= alu_result;
			branch_taken <= taken;
			target       <= target_c;
		end else if (mul_done | div_done) begin
			result       <= mul_done ? mul_product : div_result;
			branch_taken <= 1'b0;
			target       <= '0;
		end
	end

	stall_holds_outputs: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(result) &&
		$stable(branch_taken) && $stable(target));

	no_accept_while_held: assert property (@(posedge clock) disable iff (reset)
		!(in_ready && out_valid));

endmodule

`default_nettype wire

// ==== verification/tb_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exu;

	localparam int max_entries = 64;

	logic                     clock;
	logic                     reset;
	logic                     in_valid;
	logic                     in_ready;
	exu_pkg::alu_op_e         op;
	logic [exu_pkg::xlen-1:0] pc;
	logic [exu_pkg::xlen-1:0] src1;
	logic [exu_pkg::xlen-1:0] src2;
	logic [exu_pkg::xlen-1:0] imm;
	logic                     b_sel;
	logic                     out_valid;
	logic                     out_ready;
	logic [exu_pkg::xlen-1:0] result;
	logic                     branch_taken;
	logic [exu_pkg::xlen-1:0] target;

	// --------------------
	// stimulus table
	// --------------------
	exu_pkg::alu_op_e         t_op [max_entries];
	logic [exu_pkg::xlen-1:0] t_pc [max_entries];
	logic [exu_pkg::xlen-1:0] t_src1 [max_entries];
	logic [exu_pkg::xlen-1:0] t_src2 [max_entries];
	logic [exu_pkg::xlen-1:0] t_imm [max_entries];
	logic                     t_b_sel [max_entries];
	logic [exu_pkg::xlen-1:0] t_result [max_entries];
	logic                     t_taken [max_entries];
	logic [exu_pkg::xlen-1:0] t_target [max_entries];

	int num_entries;
	int cur_entry;
	int entry_errors;
	int error_count;
	int cycle_count;
	int cycle_limit;

	exu dut0 (
		.clock        (clock),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.op           (op),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.b_sel        (b_sel),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.result       (result),
		.branch_taken (branch_taken),
		.target       (target)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// stop a run that no longer makes progress
	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Some tests failed");
		$finish;
	end

	task automatic add_entry(
		input exu_pkg::alu_op_e         e_op,
		input logic [exu_pkg::xlen-1:0] e_pc,
		input logic [exu_pkg::xlen-1:0] e_src1,
		input logic [exu_pkg::xlen-1:0] e_src2,
		input logic [exu_pkg::xlen-1:0] e_imm,
		input logic                     e_b_sel,
		input logic [exu_pkg::xlen-1:0] e_result,
		input logic                     e_taken,
		input logic [exu_pkg::xlen-1:0] e_target
	);
		t_op[num_entries]     = e_op;
		t_pc[num_entries]     = e_pc;
		t_src1[num_entries]   = e_src1;
		t_src2[num_entries]   = e_src2;
		t_imm[num_entries]    = e_imm;
		t_b_sel[num_entries]  = e_b_sel;
		t_result[num_entries] = e_result;
		t_taken[num_entries]  = e_taken;
		t_target[num_entries] = e_target;
		num_entries++;
	endtask

	// register-register operation without a jump
	task automatic add_reg_op(
		input exu_pkg::alu_op_e         e_op,
		input logic [exu_pkg::xlen-1:0] e_src1,
		input logic [exu_pkg::xlen-1:0] e_src2,
		input logic [exu_pkg::xlen-1:0] e_result
	);
		add_entry(e_op, '0, e_src1, e_src2, '0, 1'b1, e_result, 1'b0, '0);
	endtask

	// branch at pc 0x400 with offset 0x20 so the target is 0x420 either way
	task automatic add_branch(
		input exu_pkg::alu_op_e         e_op,
		input logic [exu_pkg::xlen-1:0] e_src1,
		input logic [exu_pkg::xlen-1:0] e_src2,
		input logic                     e_taken
	);
		add_entry(e_op, 32'h400, e_src1, e_src2, 32'h20, 1'b1, '0, e_taken, 32'h420);
	endtask

	task automatic build_table;
		// arithmetic, logic and shifts
		add_reg_op(exu_pkg::op_add, 32'h7fffffff, 32'h00000001, 32'h80000000);
		add_reg_op(exu_pkg::op_add, 32'hffffffff, 32'h00000002, 32'h00000001);
		add_reg_op(exu_pkg::op_sub, 32'h00000005, 32'h00000007, 32'hfffffffe);
		add_reg_op(exu_pkg::op_sub, 32'h80000000, 32'h00000001, 32'h7fffffff);
		add_entry(exu_pkg::op_add, '0, 32'h100, 32'hdeadbeef, 32'hfffffff0, 1'b0,
			32'hf0, 1'b0, '0);
		add_reg_op(exu_pkg::op_xor, 32'hf0f0f0f0, 32'h0ff00ff0, 32'hff00ff00);
		add_reg_op(exu_pkg::op_or, 32'h12340000, 32'h00005678, 32'h12345678);
		add_reg_op(exu_pkg::op_and, 32'hdeadbeef, 32'h0000ffff, 32'h0000beef);
		add_reg_op(exu_pkg::op_sll, 32'h00000001, 32'h00000024, 32'h00000010);
		add_reg_op(exu_pkg::op_sll, 32'h40000001, 32'h00000021, 32'h80000002);
		add_reg_op(exu_pkg::op_srl, 32'h80000000, 32'hffffffff, 32'h00000001);
		add_reg_op(exu_pkg::op_srl, 32'hf0000000, 32'h00000004, 32'h0f000000);
		add_reg_op(exu_pkg::op_sra, 32'h80000000, 32'h00000004, 32'hf8000000);
		add_reg_op(exu_pkg::op_sra, 32'hfffffff0, 32'h00000022, 32'hfffffffc);
		// signed and unsigned order disagree
		add_reg_op(exu_pkg::op_slt, 32'hffffffff, 32'h00000001, 32'h00000001);
		add_reg_op(exu_pkg::op_sltu, 32'hffffffff, 32'h00000001, 32'h00000000);
		add_reg_op(exu_pkg::op_slt, 32'h00000001, 32'h80000000, 32'h00000000);
		add_reg_op(exu_pkg::op_sltu, 32'h00000001, 32'h80000000, 32'h00000001);
		add_reg_op(exu_pkg::op_slt, 32'h00000005, 32'h00000005, 32'h00000000);
		add_entry(exu_pkg::op_lui, '0, '0, 32'hdeadbeef, 32'h12345000, 1'b0,
			32'h12345000, 1'b0, '0);
		add_entry(exu_pkg::op_auipc, 32'h1000, '0, '0, 32'h2000, 1'b0, 32'h3000, 1'b0, '0);
		add_entry(exu_pkg::op_auipc, 32'h2000, '0, '0, 32'hfffff000, 1'b0,
			32'h1000, 1'b0, '0);
		// --------------------
		// branches and jumps
		// --------------------
		add_entry(exu_pkg::op_beq, 32'h400, 32'h7, 32'h7, 32'hfffffff0, 1'b1,
			'0, 1'b1, 32'h3f0);
		add_branch(exu_pkg::op_beq, 32'h00000007, 32'h00000008, 1'b0);
		add_branch(exu_pkg::op_bne, 32'h00000007, 32'h00000008, 1'b1);
		add_branch(exu_pkg::op_bne, 32'h00000007, 32'h00000007, 1'b0);
		add_branch(exu_pkg::op_blt, 32'hffffffff, 32'h00000001, 1'b1);
		add_branch(exu_pkg::op_blt, 32'h00000001, 32'hffffffff, 1'b0);
		add_branch(exu_pkg::op_bge, 32'h00000001, 32'hffffffff, 1'b1);
		add_branch(exu_pkg::op_bge, 32'h00000005, 32'h00000005, 1'b1);
		add_branch(exu_pkg::op_bge, 32'hffffffff, 32'h00000001, 1'b0);
		add_branch(exu_pkg::op_bltu, 32'h00000001, 32'hffffffff, 1'b1);
		add_branch(exu_pkg::op_bltu, 32'hffffffff, 32'h00000001, 1'b0);
		add_branch(exu_pkg::op_bgeu, 32'hffffffff, 32'h00000001, 1'b1);
		add_branch(exu_pkg::op_bgeu, 32'h00000001, 32'hffffffff, 1'b0);
		add_entry(exu_pkg::op_jal, 32'h800, '0, '0, 32'h100, 1'b0, 32'h804, 1'b1, 32'h900);
		add_entry(exu_pkg::op_jalr, 32'h800, 32'h1003, '0, 32'h10, 1'b0,
			32'h804, 1'b1, 32'h1012);
		// multiply with low and high halves
		add_reg_op(exu_pkg::op_mul, 32'hfffffffd, 32'h00000007, 32'hffffffeb);
		add_reg_op(exu_pkg::op_mul, 32'h12345678, 32'h00000010, 32'h23456780);
		add_reg_op(exu_pkg::op_mulh, 32'hfffffffd, 32'h00000007, 32'hffffffff);
		add_reg_op(exu_pkg::op_mulh, 32'h80000000, 32'h80000000, 32'h40000000);
		add_reg_op(exu_pkg::op_mulhsu, 32'hfffffffd, 32'hffffffff, 32'hfffffffd);
		add_reg_op(exu_pkg::op_mulhu, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
		add_reg_op(exu_pkg::op_mulhu, 32'h80000000, 32'h00000004, 32'h00000002);
		// divide with zero divisor and signed overflow
		add_reg_op(exu_pkg::op_div, 32'hffffffec, 32'h00000003, 32'hfffffffa);
		add_reg_op(exu_pkg::op_rem, 32'hffffffec, 32'h00000003, 32'hfffffffe);
		add_reg_op(exu_pkg::op_divu, 32'hffffffec, 32'h00000003, 32'h5555554e);
		add_reg_op(exu_pkg::op_remu, 32'hffffffec, 32'h00000003, 32'h00000002);
		add_reg_op(exu_pkg::op_div, 32'h00000014, 32'hfffffffd, 32'hfffffffa);
		add_reg_op(exu_pkg::op_rem, 32'h00000014, 32'hfffffffd, 32'h00000002);
		add_reg_op(exu_pkg::op_div, 32'h00000011, 32'h00000000, 32'hffffffff);
		add_reg_op(exu_pkg::op_rem, 32'hfffffffb, 32'h00000000, 32'hfffffffb);
		add_reg_op(exu_pkg::op_divu, 32'h00000011, 32'h00000000, 32'hffffffff);
		add_reg_op(exu_pkg::op_remu, 32'h00001234, 32'h00000000, 32'h00001234);
		add_reg_op(exu_pkg::op_div, 32'h80000000, 32'hffffffff, 32'h80000000);
		add_reg_op(exu_pkg::op_rem, 32'h80000000, 32'hffffffff, 32'h00000000);
	endtask

	// --------------------
	// checks
	// --------------------
	task automatic check_word(
		input string                    what,
		input logic [exu_pkg::xlen-1:0] got,
		input logic [exu_pkg::xlen-1:0] expected
	);
		if (got !== expected) begin
			$display("MISMATCH at %0t: entry %0d %s is %h, expected %h",
				$time, cur_entry, what, got, expected);
			entry_errors++;
		end
	endtask

	task automatic check_flag(
		input string what,
		input logic  got,
		input logic  expected
	);
		if (got !== expected) begin
			$display("MISMATCH at %0t: entry %0d %s is %b, expected %b",
				$time, cur_entry, what, got, expected);
			entry_errors++;
		end
	endtask

	initial begin
		logic [31:0]      seed_draw;
		logic             got_result;
		exu_pkg::alu_op_e shown;

		seed_draw = $urandom(23);
		reset     = 1'b1;
		in_valid  = 1'b0;
		op        = exu_pkg::op_add;
		pc        = '0;
		src1      = '0;
		src2      = '0;
		imm       = '0;
		b_sel     = 1'b0;
		out_ready = 1'b0;
		num_entries = 0;
		error_count = 0;
		cycle_limit = 0;
		build_table();
		cycle_limit = num_entries * 40 + 100;

		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
			$display("after reset the DUT is not ready for input or already shows a result");
			error_count++;
		end

		for (int i = 0; i < num_entries; i++) begin
			cur_entry    = i;
			entry_errors = 0;
			in_valid <= 1'b1;
			op       <= t_op[i];
			pc       <= t_pc[i];
			src1     <= t_src1[i];
			src2     <= t_src2[i];
			imm      <= t_imm[i];
			b_sel    <= t_b_sel[i];
			// a result must not show up before its operation is taken
			do begin
				@(posedge clock);
				if (out_valid === 1'b1) begin
					$display("entry %0d: a result appeared before the operation was accepted", i);
					entry_errors++;
				end
			end while (in_ready !== 1'b1);
			in_valid <= 1'b0;

			// every cycle with out_valid shows the same values whether stalled or not
			got_result = 1'b0;
			while (!got_result) begin
				@(posedge clock);
				if (out_valid === 1'b1) begin
					check_word("result", result, t_result[i]);
					check_flag("branch_taken", branch_taken, t_taken[i]);
					check_word("target", target, t_target[i]);
					got_result = out_ready;
				end
				out_ready <= (($urandom % 3) != 0);
			end

			shown = t_op[i];
			if (entry_errors == 0) begin
				$display("entry %0d %s: ok", i, shown.name());
			end else begin
				$display("entry %0d %s: %0d errors", i, shown.name(), entry_errors);
			end
			error_count += entry_errors;
		end

		// the last result must not be shown twice
		@(posedge clock);
		if (out_valid === 1'b1) begin
			$display("the last result was still shown after it was consumed");
			error_count++;
		end

		$display("%0d entries run, %0d errors", num_entries, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/exu_pkg.sv
source/exu_adder.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_mul.sv
source/exu_div.sv
source/exu.sv
verification/tb_exu.sv

// ==== Bender.yml ====
package:
  name: exu

sources:
  - source/exu_pkg.sv
  - source/exu_adder.sv
  - source/exu_alu.sv
  - source/exu_branch.sv
  - source/exu_mul.sv
  - source/exu_div.sv
  - source/exu.sv
  - target: test
    files:
      - verification/tb_exu.sv
